/* verilog/spi_bus_pkg.sv */
package spi_bus_pkg;

  // Wishbone master request, one single-word access
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  // Slave response
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_rsp_t;

  // Address map
  localparam logic [31:0] SYS_BASE  = 32'h0000_0000;
  localparam logic [31:0] SYS_HIGH  = 32'h0000_FFFF;
  localparam logic [31:0] GPIO_BASE = 32'h0001_0000;
  localparam logic [31:0] GPIO_HIGH = 32'h0001_FFFF;

  // Board identification
  localparam logic [15:0] BOARD_ID = 16'd12;
  localparam logic [7:0]  REV_MAJ  = 8'd1;
  localparam logic [7:0]  REV_MIN  = 8'd0;
  localparam logic [31:0] REV_RCS  = 32'h0;

  localparam int GPIO_W = 8;

  // Decoder waits this many cycles for a slave ack
  localparam int BUS_TIMEOUT = 32;
  localparam int TMO_W       = $clog2(BUS_TIMEOUT + 1);

  localparam int SCLK_SYNC = 2; // Flops on sclk, cs_n and mosi

  // Status byte sent at the end of every frame
  localparam logic [7:0] STAT_ACK = 8'h01;
  localparam logic [7:0] STAT_ERR = 8'h02;

endpackage

/* verilog/spi_wb_bridge.sv */
module spi_wb_bridge (
  input  logic                 sys_clk,
  input  logic                 rst_i,
  input  logic                 cs_n_i,
  input  logic                 sclk_i,
  input  logic                 mosi_i,
  output logic                 miso_o,
  output spi_bus_pkg::wb_req_t wb_req_o,
  input  spi_bus_pkg::wb_rsp_t wb_rsp_i,
  output logic                 new_cmd_o
);

  typedef enum logic [2:0] {
    ST_CMD,
    ST_ADDR,
    ST_WDATA,
    ST_TURN,
    ST_RDATA,
    ST_STAT,
    ST_DONE
  } state_t;

  logic [spi_bus_pkg::SCLK_SYNC-1:0] sclk_sr;
  logic [spi_bus_pkg::SCLK_SYNC-1:0] cs_sr;
  logic [spi_bus_pkg::SCLK_SYNC-1:0] mosi_sr;
  logic        sclk_d;
  logic        sclk_s;
  logic        mosi_s;
  logic        cs_act;
  logic        sclk_rise;
  logic        sclk_fall;

  state_t      state;
  logic [5:0]  bit_cnt;
  logic        is_wr;
  logic [31:0] in_sr;
  logic [39:0] out_sr;    // Read data then status, MSB first
  logic [31:0] rd_data;
  logic [7:0]  stat;

  assign sclk_s    = sclk_sr[spi_bus_pkg::SCLK_SYNC-1];
  assign mosi_s    = mosi_sr[spi_bus_pkg::SCLK_SYNC-1];
  assign cs_act    = ~cs_sr[spi_bus_pkg::SCLK_SYNC-1];
  assign sclk_rise = sclk_s & ~sclk_d;
  assign sclk_fall = ~sclk_s & sclk_d;

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      sclk_sr <= '0;
      cs_sr   <= '1; // Deselected
      mosi_sr <= '0;
      sclk_d  <= 1'b0;
    end else begin
      sclk_sr <= {sclk_sr[spi_bus_pkg::SCLK_SYNC-2:0], sclk_i};
      cs_sr   <= {cs_sr[spi_bus_pkg::SCLK_SYNC-2:0], cs_n_i};
      mosi_sr <= {mosi_sr[spi_bus_pkg::SCLK_SYNC-2:0], mosi_i};
      sclk_d  <= sclk_s;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      state     <= ST_CMD;
      bit_cnt   <= '0;
      is_wr     <= 1'b0;
      stat      <= '0;
      wb_req_o  <= '0;
      new_cmd_o <= 1'b0;
      miso_o    <= 1'b0;
    end else if (!cs_act) begin
      // Frame aborted or idle
      state        <= ST_CMD;
      bit_cnt      <= '0;
      stat         <= '0;
      wb_req_o.cyc <= 1'b0;
      wb_req_o.stb <= 1'b0;
      new_cmd_o    <= 1'b0;
      miso_o       <= 1'b0;
    end else begin
      new_cmd_o <= 1'b0;

      if (wb_req_o.stb && (wb_rsp_i.ack || wb_rsp_i.err)) begin
        wb_req_o.cyc <= 1'b0;
        wb_req_o.stb <= 1'b0;
        rd_data      <= wb_rsp_i.dat;
        stat         <= wb_rsp_i.ack ? spi_bus_pkg::STAT_ACK : spi_bus_pkg::STAT_ERR;
      end

      if (sclk_rise) begin
        in_sr   <= {in_sr[30:0], mosi_s};
        bit_cnt <= bit_cnt + 6'd1;
        case (state)
          ST_CMD: begin
            if (bit_cnt == 6'd7) begin
              is_wr     <= in_sr[6]; // First bit of the command byte
              new_cmd_o <= 1'b1;
              state     <= ST_ADDR;
              bit_cnt   <= '0;
            end
          end
          ST_ADDR: begin
            if (bit_cnt == 6'd31) begin
              wb_req_o.adr <= {in_sr[30:0], mosi_s};
              bit_cnt      <= '0;
              if (is_wr) begin
                state <= ST_WDATA;
              end else begin
                wb_req_o.cyc <= 1'b1;
                wb_req_o.stb <= 1'b1;
                wb_req_o.we  <= 1'b0;
                wb_req_o.sel <= 4'hF;
                state        <= ST_TURN;
              end
            end
          end
          ST_WDATA: begin
            if (bit_cnt == 6'd31) begin
              wb_req_o.dat <= {in_sr[30:0], mosi_s};
              wb_req_o.cyc <= 1'b1;
              wb_req_o.stb <= 1'b1;
              wb_req_o.we  <= 1'b1;
              wb_req_o.sel <= 4'hF;
              bit_cnt      <= '0;
              state        <= ST_TURN;
            end
          end
          ST_TURN: begin
            if (bit_cnt == 6'd7) begin
              out_sr  <= is_wr ? {stat, 32'h0} : {rd_data, stat};
              bit_cnt <= '0;
              state   <= is_wr ? ST_STAT : ST_RDATA;
            end
          end
          ST_RDATA: begin
            if (bit_cnt == 6'd31) begin
              bit_cnt <= '0;
              state   <= ST_STAT;
            end
          end
          ST_STAT: begin
            if (bit_cnt == 6'd7) begin
              state <= ST_DONE;
            end
          end
          default: ; // Wait for cs_n to rise
        endcase
      end

      // Mode 0, miso moves on the falling edge
      if (sclk_fall && (state == ST_RDATA || state == ST_STAT)) begin
        miso_o <= out_sr[39];
        out_sr <= {out_sr[38:0], 1'b0};
      end
    end
  end

  a_req_stable: assert property (@(posedge sys_clk) disable iff (rst_i)
    wb_req_o.stb && !wb_rsp_i.ack && !wb_rsp_i.err && cs_act |=> $stable(wb_req_o));

  a_rsp_excl: assert property (@(posedge sys_clk) disable iff (rst_i)
    !(wb_rsp_i.ack && wb_rsp_i.err));

endmodule

/* verilog/wbs_decoder.sv */
module wbs_decoder (
  input  logic                 sys_clk,
  input  logic                 rst_i,
  input  spi_bus_pkg::wb_req_t m_req_i,
  output spi_bus_pkg::wb_rsp_t m_rsp_o,
  output spi_bus_pkg::wb_req_t sys_req_o,
  input  spi_bus_pkg::wb_rsp_t sys_rsp_i,
  output spi_bus_pkg::wb_req_t gpio_req_o,
  input  spi_bus_pkg::wb_rsp_t gpio_rsp_i
);

  logic                          hit_sys;
  logic                          hit_gpio;
  logic [1:0]                    sel_q;   // {gpio, sys}
  logic                          busy;
  logic                          done;
  logic [spi_bus_pkg::TMO_W-1:0] tmo_cnt;
  spi_bus_pkg::wb_rsp_t          slv_rsp;

  assign hit_sys  = (m_req_i.adr >= spi_bus_pkg::SYS_BASE) &&
                    (m_req_i.adr <= spi_bus_pkg::SYS_HIGH);
  assign hit_gpio = (m_req_i.adr >= spi_bus_pkg::GPIO_BASE) &&
                    (m_req_i.adr <= spi_bus_pkg::GPIO_HIGH);

  assign slv_rsp = sel_q[0] ? sys_rsp_i : gpio_rsp_i;

  // Strobe drops once the slave has answered
  always_comb begin
    sys_req_o      = m_req_i;
    sys_req_o.cyc  = m_req_i.cyc & sel_q[0];
    sys_req_o.stb  = m_req_i.stb & sel_q[0] & ~done;
    gpio_req_o     = m_req_i;
    gpio_req_o.cyc = m_req_i.cyc & sel_q[1];
    gpio_req_o.stb = m_req_i.stb & sel_q[1] & ~done;
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      m_rsp_o <= '0;
      sel_q   <= '0;
      busy    <= 1'b0;
      done    <= 1'b0;
      tmo_cnt <= '0;
    end else begin
      m_rsp_o.ack <= 1'b0;
      m_rsp_o.err <= 1'b0;
      if (!m_req_i.cyc) begin
        sel_q <= '0;
        busy  <= 1'b0;
        done  <= 1'b0;
      end else if (!busy) begin
        if (m_req_i.stb) begin
          busy    <= 1'b1;
          sel_q   <= {hit_gpio, hit_sys};
          tmo_cnt <= spi_bus_pkg::TMO_W'(1);
          if (!hit_sys && !hit_gpio) begin
            m_rsp_o.err <= 1'b1; // Unmapped
            m_rsp_o.dat <= '0;
            done        <= 1'b1;
          end
        end
      end else if (!done) begin
        tmo_cnt <= tmo_cnt + 1'b1;
        if (slv_rsp.ack || slv_rsp.err) begin
          m_rsp_o <= slv_rsp;
          done    <= 1'b1;
        end else if (tmo_cnt == spi_bus_pkg::TMO_W'(spi_bus_pkg::BUS_TIMEOUT)) begin
          m_rsp_o.err <= 1'b1;
          m_rsp_o.dat <= '0;
          done        <= 1'b1;
        end
      end
    end
  end

  a_one_slave: assert property (@(posedge sys_clk) disable iff (rst_i)
    !(sys_req_o.stb && gpio_req_o.stb));

endmodule

/* verilog/sys_block.sv */
module sys_block (
  input  logic                 sys_clk,
  input  logic                 rst_i,
  input  spi_bus_pkg::wb_req_t req_i,
  output spi_bus_pkg::wb_rsp_t rsp_o,
  output logic [31:0]          debug_o
);

  logic        acc;
  logic        ack_q;
  logic [31:0] rd_q;
  logic [31:0] scratch;
  logic [31:0] debug_q;
  logic [31:0] rd_mux;

  // One ack per strobe
  assign acc = req_i.cyc & req_i.stb & ~ack_q;

  always_comb begin
    case (req_i.adr[15:0])
      16'h0:   rd_mux = {spi_bus_pkg::BOARD_ID, spi_bus_pkg::REV_MAJ, spi_bus_pkg::REV_MIN};
      16'h4:   rd_mux = spi_bus_pkg::REV_RCS;
      16'h8:   rd_mux = scratch;
      16'hC:   rd_mux = debug_q;
      default: rd_mux = '0;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      ack_q   <= 1'b0;
      scratch <= '0;
      debug_q <= '0;
    end else begin
      ack_q <= acc;
      if (acc && req_i.we) begin
        for (int i = 0; i < 4; i++) begin
          if (req_i.sel[i]) begin
            if (req_i.adr[15:0] == 16'h8) begin
              scratch[8*i +: 8] <= req_i.dat[8*i +: 8];
            end
            if (req_i.adr[15:0] == 16'hC) begin
              debug_q[8*i +: 8] <= req_i.dat[8*i +: 8];
            end
          end
        end
      end
    end
  end

  // Read data, old value on a write
  always_ff @(posedge sys_clk) begin
    if (acc) begin
      rd_q <= rd_mux;
    end
  end

  assign rsp_o   = '{dat: rd_q, ack: ack_q, err: 1'b0};
  assign debug_o = debug_q;

endmodule

/* verilog/gpio_block.sv */
module gpio_block (
  input  logic                           sys_clk,
  input  logic                           rst_i,
  input  spi_bus_pkg::wb_req_t           req_i,
  output spi_bus_pkg::wb_rsp_t           rsp_o,
  input  logic [spi_bus_pkg::GPIO_W-1:0] gpio_i,
  output logic [spi_bus_pkg::GPIO_W-1:0] gpio_o,
  input  logic                           new_cmd_i
);

  logic                           acc;
  logic                           ack_q;
  logic [31:0]                    rd_q;
  logic [31:0]                    rd_mux;
  logic [31:0]                    cmd_cnt;
  logic [spi_bus_pkg::GPIO_W-1:0] out_q;
  logic [spi_bus_pkg::GPIO_W-1:0] wr_bits;
  logic [spi_bus_pkg::GPIO_W-1:0] in_s1;
  logic [spi_bus_pkg::GPIO_W-1:0] in_s2;

  assign acc     = req_i.cyc & req_i.stb & ~ack_q;
  assign wr_bits = req_i.dat[spi_bus_pkg::GPIO_W-1:0];

  always_comb begin
    case (req_i.adr[15:0])
      16'h0:   rd_mux = {{(32 - spi_bus_pkg::GPIO_W){1'b0}}, out_q};
      16'hC:   rd_mux = {{(32 - spi_bus_pkg::GPIO_W){1'b0}}, in_s2};
      16'h10:  rd_mux = cmd_cnt;
      default: rd_mux = '0; // Set and clear read zero
    endcase
  end

  always_ff @(posedge sys_clk) begin
    in_s1 <= gpio_i; // Pins are asynchronous
    in_s2 <= in_s1;
    if (acc) begin
      rd_q <= rd_mux;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      ack_q   <= 1'b0;
      out_q   <= '0;
      cmd_cnt <= '0;
    end else begin
      ack_q <= acc;
      if (new_cmd_i) begin
        cmd_cnt <= cmd_cnt + 32'd1;
      end
      if (acc && req_i.we && req_i.sel[0]) begin
        case (req_i.adr[15:0])
          16'h0:   out_q <= wr_bits;
          16'h4:   out_q <= out_q | wr_bits;
          16'h8:   out_q <= out_q & ~wr_bits;
          default: ;
        endcase
      end
    end
  end

  assign rsp_o  = '{dat: rd_q, ack: ack_q, err: 1'b0};
  assign gpio_o = out_q;

endmodule

/* verilog/spi_wb_top.sv */
module spi_wb_top (
  input  logic                           sys_clk,
  input  logic                           rst_i,
  input  logic                           cs_n_i,
  input  logic                           sclk_i,
  input  logic                           mosi_i,
  output logic                           miso_o,
  input  logic [spi_bus_pkg::GPIO_W-1:0] gpio_i,
  output logic [spi_bus_pkg::GPIO_W-1:0] gpio_o,
  output logic [31:0]                    debug_o
);

  spi_bus_pkg::wb_req_t m_req;
  spi_bus_pkg::wb_rsp_t m_rsp;
  spi_bus_pkg::wb_req_t sys_req;
  spi_bus_pkg::wb_rsp_t sys_rsp;
  spi_bus_pkg::wb_req_t gpio_req;
  spi_bus_pkg::wb_rsp_t gpio_rsp;
  logic                 new_cmd;

  spi_wb_bridge i_bridge (
    .sys_clk   (sys_clk),
    .rst_i     (rst_i),
    .cs_n_i    (cs_n_i),
    .sclk_i    (sclk_i),
    .mosi_i    (mosi_i),
    .miso_o    (miso_o),
    .wb_req_o  (m_req),
    .wb_rsp_i  (m_rsp),
    .new_cmd_o (new_cmd)
  );

  wbs_decoder i_decoder (
    .sys_clk    (sys_clk),
    .rst_i      (rst_i),
    .m_req_i    (m_req),
    .m_rsp_o    (m_rsp),
    .sys_req_o  (sys_req),
    .sys_rsp_i  (sys_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp)
  );

  sys_block i_sys (
    .sys_clk (sys_clk),
    .rst_i   (rst_i),
    .req_i   (sys_req),
    .rsp_o   (sys_rsp),
    .debug_o (debug_o)
  );

  gpio_block i_gpio (
    .sys_clk   (sys_clk),
    .rst_i     (rst_i),
    .req_i     (gpio_req),
    .rsp_o     (gpio_rsp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .new_cmd_i (new_cmd)
  );

endmodule

/* tb/tb_spi_master.svh */
`ifndef TB_SPI_MASTER_SVH
`define TB_SPI_MASTER_SVH

logic [31:0] lcg_state = 32'h4dc;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// One sclk period, 4 sys_clk cycles low then 4 high
task automatic shift_bit(input logic out_bit, output logic in_bit);
  @(posedge sys_clk);
  sclk <= 1'b0;
  mosi <= out_bit;
  repeat (3) @(posedge sys_clk);
  @(negedge sys_clk);
  in_bit = miso; // Settled since the falling edge
  @(posedge sys_clk);
  sclk <= 1'b1;
  repeat (3) @(posedge sys_clk);
endtask

// MSB first, nbits taken from the low end of out_word
task automatic shift_word(input logic [31:0] out_word, input int nbits,
                          output logic [31:0] in_word);
  logic b;
  in_word = '0;
  for (int i = nbits - 1; i >= 0; i--) begin
    shift_bit(out_word[i], b);
    in_word = {in_word[30:0], b};
  end
endtask

task automatic run_frame(input logic [7:0] cmd, input logic [31:0] addr,
                         input logic [31:0] wdata, output logic [31:0] rdata,
                         output logic [7:0] status);
  logic [31:0] unused;
  logic [31:0] st_word;
  rdata = '0;
  @(posedge sys_clk);
  cs_n <= 1'b0;
  repeat (4) @(posedge sys_clk);
  shift_word({24'h0, cmd}, 8, unused);
  shift_word(addr, 32, unused);
  if (cmd[7]) begin
    shift_word(wdata, 32, unused);
  end
  shift_word(32'h0, 8, unused); // Turnaround, bus access runs here
  if (!cmd[7]) begin
    shift_word(32'h0, 32, rdata);
  end
  shift_word(32'h0, 8, st_word);
  status = st_word[7:0];
  @(posedge sys_clk);
  sclk <= 1'b0;
  repeat (4) @(posedge sys_clk);
  cs_n <= 1'b1;
  repeat (8) @(posedge sys_clk); // Gap between frames
endtask

task automatic spi_write(input logic [31:0] addr, input logic [31:0] data,
                         output logic [7:0] status);
  logic [31:0] unused;
  run_frame(8'h80, addr, data, unused, status);
endtask

task automatic spi_read(input logic [31:0] addr, output logic [31:0] data,
                        output logic [7:0] status);
  run_frame(8'h00, addr, 32'h0, data, status);
endtask

task automatic settle_gpio(input logic [spi_bus_pkg::GPIO_W-1:0] exp);
  int n;
  n = 0;
  @(negedge sys_clk);
  while (gpio_out !== exp && n < 16) begin
    @(negedge sys_clk);
    n++;
  end
  if (gpio_out !== exp) begin
    $display("Timeout waiting for gpio_o to settle after a frame");
  end
  check_gpio("gpio_o", gpio_out, exp);
endtask

task automatic settle_debug(input logic [31:0] exp);
  int n;
  n = 0;
  @(negedge sys_clk);
  while (debug_out !== exp && n < 16) begin
    @(negedge sys_clk);
    n++;
  end
  if (debug_out !== exp) begin
    $display("Timeout waiting for debug_o to settle after a frame");
  end
  check_word("debug_o", debug_out, exp);
endtask

`endif

/* tb/tb_spi_wb_top.sv */
module tb_spi_wb_top;
  timeunit 1ns;
  timeprecision 100ps;

  logic                           sys_clk;
  logic                           rst;
  logic                           cs_n;
  logic                           sclk;
  logic                           mosi;
  logic                           miso;
  logic [spi_bus_pkg::GPIO_W-1:0] gpio_in;
  logic [spi_bus_pkg::GPIO_W-1:0] gpio_out;
  logic [31:0]                    debug_out;

  task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_status(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_gpio(input string name, input logic [spi_bus_pkg::GPIO_W-1:0] got,
                            input logic [spi_bus_pkg::GPIO_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  `include "tb_spi_master.svh"

  spi_wb_top i_dut (
    .sys_clk (sys_clk),
    .rst_i   (rst),
    .cs_n_i  (cs_n),
    .sclk_i  (sclk),
    .mosi_i  (mosi),
    .miso_o  (miso),
    .gpio_i  (gpio_in),
    .gpio_o  (gpio_out),
    .debug_o (debug_out)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  task automatic read_ident();
    logic [31:0] d;
    logic [7:0]  st;
    spi_read(spi_bus_pkg::SYS_BASE, d, st);
    check_status("ident status", st, spi_bus_pkg::STAT_ACK);
    check_word("ident word", d,
               {spi_bus_pkg::BOARD_ID, spi_bus_pkg::REV_MAJ, spi_bus_pkg::REV_MIN});
    spi_read(spi_bus_pkg::SYS_BASE + 32'h4, d, st);
    check_status("rcs status", st, spi_bus_pkg::STAT_ACK);
    check_word("rev rcs", d, spi_bus_pkg::REV_RCS);
  endtask

  task automatic scratch_debug_rw();
    logic [31:0] w_scr;
    logic [31:0] w_dbg;
    logic [31:0] d;
    logic [7:0]  st;
    w_scr = lcg_next();
    w_dbg = lcg_next();
    spi_write(spi_bus_pkg::SYS_BASE + 32'h8, w_scr, st);
    check_status("scratch write status", st, spi_bus_pkg::STAT_ACK);
    spi_write(spi_bus_pkg::SYS_BASE + 32'hC, w_dbg, st);
    check_status("debug write status", st, spi_bus_pkg::STAT_ACK);
    settle_debug(w_dbg);
    spi_read(spi_bus_pkg::SYS_BASE + 32'h8, d, st);
    check_status("scratch read status", st, spi_bus_pkg::STAT_ACK);
    check_word("scratch", d, w_scr);
    spi_read(spi_bus_pkg::SYS_BASE + 32'hC, d, st);
    check_status("debug read status", st, spi_bus_pkg::STAT_ACK);
    check_word("debug reg", d, w_dbg);
  endtask

  task automatic gpio_output_ops();
    logic [31:0]                    w;
    logic [31:0]                    d;
    logic [7:0]                     st;
    logic [spi_bus_pkg::GPIO_W-1:0] exp;
    w = lcg_next();
    spi_write(spi_bus_pkg::GPIO_BASE, w, st);
    check_status("gpio out status", st, spi_bus_pkg::STAT_ACK);
    exp = w[spi_bus_pkg::GPIO_W-1:0];
    settle_gpio(exp);
    w = lcg_next();
    w[spi_bus_pkg::GPIO_W-1:0] = w[spi_bus_pkg::GPIO_W-1:0] | ~exp; // Reach every clear bit
    spi_write(spi_bus_pkg::GPIO_BASE + 32'h4, w, st);
    check_status("gpio set status", st, spi_bus_pkg::STAT_ACK);
    exp = exp | w[spi_bus_pkg::GPIO_W-1:0]; // Set bits
    settle_gpio(exp);
    w = lcg_next();
    spi_write(spi_bus_pkg::GPIO_BASE + 32'h8, w, st);
    check_status("gpio clear status", st, spi_bus_pkg::STAT_ACK);
    exp = exp & ~w[spi_bus_pkg::GPIO_W-1:0];
    settle_gpio(exp);
    spi_read(spi_bus_pkg::GPIO_BASE, d, st);
    check_status("gpio read status", st, spi_bus_pkg::STAT_ACK);
    check_word("gpio out reg", d, 32'(exp));
  endtask

  task automatic gpio_input_readback();
    logic [31:0] v;
    logic [31:0] d;
    logic [7:0]  st;
    v = lcg_next();
    @(posedge sys_clk);
    gpio_in <= v[spi_bus_pkg::GPIO_W-1:0];
    repeat (6) @(posedge sys_clk); // Through the input synchronizer
    spi_read(spi_bus_pkg::GPIO_BASE + 32'hC, d, st);
    check_status("gpio in status", st, spi_bus_pkg::STAT_ACK);
    check_word("gpio in readback", d, 32'(v[spi_bus_pkg::GPIO_W-1:0]));
  endtask

  task automatic command_counter();
    logic [31:0] c1;
    logic [31:0] c2;
    logic [31:0] d;
    logic [7:0]  st;
    spi_read(spi_bus_pkg::GPIO_BASE + 32'h10, c1, st);
    check_status("counter status", st, spi_bus_pkg::STAT_ACK);
    for (int i = 0; i < 3; i++) begin
      spi_read(spi_bus_pkg::SYS_BASE + 32'h4, d, st);
    end
    spi_read(spi_bus_pkg::GPIO_BASE + 32'h10, c2, st);
    check_word("command count delta", c2 - c1, 32'd4); // Three frames plus this read
  endtask

  task automatic unmapped_error();
    logic [31:0] d;
    logic [7:0]  st;
    spi_read(32'h0002_0000, d, st);
    check_status("unmapped status", st, spi_bus_pkg::STAT_ERR);
    check_word("unmapped data", d, 32'h0);
    spi_read(spi_bus_pkg::SYS_BASE, d, st);
    check_status("status after error", st, spi_bus_pkg::STAT_ACK);
    check_word("ident after error", d,
               {spi_bus_pkg::BOARD_ID, spi_bus_pkg::REV_MAJ, spi_bus_pkg::REV_MIN});
  endtask

  initial begin
    rst     <= 1'b1;
    cs_n    <= 1'b1;
    sclk    <= 1'b0;
    mosi    <= 1'b0;
    gpio_in <= '0;
    repeat (5) @(posedge sys_clk);
    rst <= 1'b0;
    @(negedge sys_clk);
    check_gpio("gpio_o after reset", gpio_out, '0);
    check_word("debug_o after reset", debug_out, 32'h0);
    read_ident();
    scratch_debug_rw();
    gpio_output_ops();
    gpio_input_readback();
    command_counter();
    unmapped_error();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* flist.f */
+incdir+tb
verilog/spi_bus_pkg.sv
verilog/spi_wb_bridge.sv
verilog/wbs_decoder.sv
verilog/sys_block.sv
verilog/gpio_block.sv
verilog/spi_wb_top.sv
tb/tb_spi_wb_top.sv
